// ==== flist.f ====
logic/alu_pkg.sv
logic/instr_decode.sv
logic/cla_adder.sv
logic/csa_multiplier.sv
logic/result_select.sv
logic/alu_top.sv
test/alu_properties.sv
test/alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ALU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module alu_tb \
    -Mdir obj_dir \
    -o alu_sim

./obj_dir/alu_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"

// ==== test/alu_tb.sv ====
`timescale 1ns/10ps

module alu_tb
    import alu_pkg::*;
;

    localparam int reset_cycles  = 16;
    localparam int table_rows    = 24;
    localparam int rand_count    = 64;
    localparam int timeout_limit = reset_cycles + table_rows + rand_count + 20;

    typedef struct packed {
        alu_op_e   op;
        alu_data_t a;
        alu_data_t b;
        alu_data_t res;
        logic      ovf;
    } vector_t;

    typedef struct packed {
        alu_op_e   op;
        alu_data_t a;
        alu_data_t b;
        alu_data_t res;
        logic      ovf;
        int        due;
    } expect_t;

    logic       clk;
    logic       rst_n;
    logic       instr_valid;
    alu_instr_t instr;
    logic       result_valid;
    alu_data_t  result;
    logic       overflow;

    vector_t     vectors [table_rows];
    expect_t     exp_q [$];
    logic [31:0] lfsr_state;
    int          neg_count   = 0;
    int          error_count = 0;
    int          tests_run   = 0;
    int          issued      = 0;

    alu_top #(.DATA_W(data_width)) u_alu_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result),
        .overflow     (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // directed rows of opcode, a, b, expected result and expected overflow
    task automatic load_vectors();
        vectors[0]  = '{op_add,  8'h12, 8'h34, 8'h46, 1'b0};
        vectors[1]  = '{op_add,  8'hff, 8'h01, 8'h00, 1'b1};
        vectors[2]  = '{op_add,  8'h80, 8'h80, 8'h00, 1'b1};
        vectors[3]  = '{op_add,  8'h7f, 8'h01, 8'h80, 1'b0};
        vectors[4]  = '{op_sub,  8'h00, 8'h01, 8'hff, 1'b1};
        vectors[5]  = '{op_sub,  8'h50, 8'h20, 8'h30, 1'b0};
        vectors[6]  = '{op_sub,  8'h20, 8'h20, 8'h00, 1'b0};
        vectors[7]  = '{op_sub,  8'h10, 8'h80, 8'h90, 1'b1};
        vectors[8]  = '{op_mulu, 8'h10, 8'h10, 8'h00, 1'b1};
        vectors[9]  = '{op_mulu, 8'h0f, 8'h11, 8'hff, 1'b0};
        vectors[10] = '{op_mulu, 8'hff, 8'hff, 8'h01, 1'b1};
        vectors[11] = '{op_mulu, 8'h00, 8'hab, 8'h00, 1'b0};
        // -128 * -1 leaves the signed byte range
        vectors[12] = '{op_muls, 8'h80, 8'hff, 8'h80, 1'b1};
        vectors[13] = '{op_muls, 8'hf8, 8'h10, 8'h80, 1'b0};
        vectors[14] = '{op_muls, 8'hfe, 8'h03, 8'hfa, 1'b0};
        vectors[15] = '{op_muls, 8'h7f, 8'h7f, 8'h01, 1'b1};
        vectors[16] = '{op_muls, 8'hff, 8'hff, 8'h01, 1'b0};
        vectors[17] = '{op_muls, 8'h80, 8'h80, 8'h00, 1'b1};
        vectors[18] = '{op_cmp,  8'ha5, 8'h5a, 8'hff, 1'b0};
        vectors[19] = '{op_cmp,  8'h3c, 8'h3c, 8'h00, 1'b0};
        vectors[20] = '{op_none, 8'hff, 8'hff, 8'h00, 1'b0};
        vectors[21] = '{op_fadd, 8'h12, 8'h34, 8'h00, 1'b0};
        vectors[22] = '{op_fmul, 8'hff, 8'h01, 8'h00, 1'b0};
        vectors[23] = '{op_cmp,  8'h0f, 8'h33, 8'h3c, 1'b0};
    endtask

    // 32-bit Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    // expected values worked out with integer arithmetic
    task automatic predict(input alu_op_e op, input alu_data_t a, input alu_data_t b,
                           output alu_data_t res, output logic ovf);
        int x;
        int y;
        int r;
        res = '0;
        ovf = 1'b0;
        x = int'(a);
        y = int'(b);
        case (op)
            op_add: begin
                r = x + y;
                res = r[7:0];
                ovf = (r > 255);
            end
            op_sub: begin
                r = x - y;
                res = r[7:0];
                ovf = (x < y);
            end
            op_mulu: begin
                r = x * y;
                res = r[7:0];
                ovf = (r > 255);
            end
            op_muls: begin
                x = int'($signed(a));
                y = int'($signed(b));
                r = x * y;
                res = r[7:0];
                ovf = (r < -128) || (r > 127);
            end
            op_cmp: begin
                res = a ^ b;
            end
            default: begin
                res = '0;
            end
        endcase
    endtask

    task automatic issue(input alu_op_e op, input alu_data_t a, input alu_data_t b,
                         input alu_data_t res, input logic ovf);
        expect_t e;
        @(posedge clk);
        instr.op    <= op;
        instr.a     <= a;
        instr.b     <= b;
        instr_valid <= 1'b1;
        e.op  = op;
        e.a   = a;
        e.b   = b;
        e.res = res;
        e.ovf = ovf;
        // decode edge, result edge, then the falling edge after it
        e.due = neg_count + 3;
        exp_q.push_back(e);
        issued++;
    endtask

    task automatic check_result(input alu_data_t got, input alu_data_t exp);
        if (got !== exp) begin
            $display("Fail result: got 0x%02h, expected 0x%02h", got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail overflow: got 0x%0h, expected 0x%0h", got, exp);
            error_count++;
        end
    endtask

    // outputs are sampled on the falling edge
    initial begin : monitor
        expect_t e;
        int      errs_before;
        forever begin
            @(negedge clk);
            neg_count++;
            if (exp_q.size() > 0 && exp_q[0].due == neg_count) begin
                e = exp_q.pop_front();
                tests_run++;
                errs_before = error_count;
                if (result_valid !== 1'b1) begin
                    $display("result_valid stayed low two edges after test %0d was issued",
                             tests_run);
                    error_count++;
                end
                check_result(result, e.res);
                check_flag(overflow, e.ovf);
                if (error_count == errs_before) begin
                    $display("test %0d %s a=0x%02h b=0x%02h result=0x%02h overflow=%0d ok",
                             tests_run, e.op.name(), e.a, e.b, result, overflow);
                end else begin
                    $display("test %0d %s a=0x%02h b=0x%02h mismatch",
                             tests_run, e.op.name(), e.a, e.b);
                end
            end else if (result_valid !== 1'b0) begin
                $display("result_valid was high with no instruction due");
                error_count++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", timeout_limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        vector_t    v;
        alu_op_e    op;
        alu_data_t  a;
        alu_data_t  b;
        alu_data_t  res;
        logic       ovf;
        logic [7:0] bits;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr_state  = 32'd72481;
        load_vectors();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // directed table issued back to back
        for (int i = 0; i < table_rows; i++) begin
            v = vectors[i];
            issue(v.op, v.a, v.b, v.res, v.ovf);
        end

        // a short gap where result_valid must drop
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= '0;
        @(posedge clk);

        for (int i = 0; i < rand_count; i++) begin
            take_bits(3, bits);
            op = alu_op_e'(bits[2:0]);
            take_bits(8, bits);
            a = bits;
            take_bits(8, bits);
            b = bits;
            predict(op, a, b, res, ovf);
            issue(op, a, b, res, ovf);
        end
        @(posedge clk);
        instr_valid <= 1'b0;

        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);

        $display("summary: %0d issued, %0d checked, %0d errors", issued, tests_run, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== test/alu_properties.sv ====
`timescale 1ns/10ps

module alu_properties
    import alu_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       instr_valid,
    input alu_instr_t instr,
    input logic       result_valid,
    input alu_data_t  result,
    input logic       overflow
);

    // two register stages between the strobe and the result
    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid == $past(instr_valid, 2))
        else $error("result_valid does not follow instr_valid by two edges");

    a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !result_valid |-> (result == '0 && !overflow))
        else $error("result or overflow nonzero while result_valid is low");

    // compare, zero and reserved opcodes never raise the flag
    a_flag_low: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_valid && (instr.op inside {op_none, op_fadd, op_fmul, op_cmp}))
        |-> ##2 !overflow)
        else $error("overflow set for an opcode without a range check");

endmodule

bind alu_top alu_properties u_alu_properties (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result       (result),
    .overflow     (overflow)
);

// ==== logic/alu_top.sv ====
`timescale 1ns/10ps

module alu_top
    import alu_pkg::*;
#(
    parameter int DATA_W = data_width
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  alu_instr_t instr,
    output logic       result_valid,
    output alu_data_t  result,
    output logic       overflow
);

    logic      stage_valid;
    alu_data_t stage_a;
    alu_data_t stage_b;
    alu_ctrl_t stage_ctrl;
    alu_data_t sum;
    logic      carry;
    alu_prod_t product;
    logic      mul_overflow;

    // stage one
    instr_decode #(.DATA_W(DATA_W)) u_instr_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stage_valid (stage_valid),
        .stage_a     (stage_a),
        .stage_b     (stage_b),
        .stage_ctrl  (stage_ctrl)
    );

    // add and subtract share the one adder
    cla_adder #(.DATA_W(DATA_W)) u_cla_adder (
        .a     (stage_a),
        .b     (stage_b),
        .sub   (stage_ctrl.sub),
        .sum   (sum),
        .carry (carry)
    );

    csa_multiplier #(.DATA_W(DATA_W)) u_csa_multiplier (
        .a            (stage_a),
        .b            (stage_b),
        .mul_signed   (stage_ctrl.mul_signed),
        .product      (product),
        .mul_overflow (mul_overflow)
    );

    // stage two
    result_select #(.DATA_W(DATA_W)) u_result_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage_valid  (stage_valid),
        .stage_ctrl   (stage_ctrl),
        .stage_a      (stage_a),
        .stage_b      (stage_b),
        .sum          (sum),
        .carry        (carry),
        .product      (product),
        .mul_overflow (mul_overflow),
        .result_valid (result_valid),
        .result       (result),
        .overflow     (overflow)
    );

endmodule

// ==== logic/result_select.sv ====
`timescale 1ns/10ps

module result_select
    import alu_pkg::*;
#(
    parameter int DATA_W = data_width
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stage_valid,
    input  alu_ctrl_t stage_ctrl,
    input  alu_data_t stage_a,
    input  alu_data_t stage_b,
    input  alu_data_t sum,
    input  logic      carry,
    input  alu_prod_t product,
    input  logic      mul_overflow,
    output logic      result_valid,
    output alu_data_t result,
    output logic      overflow
);

    alu_data_t cmp_res;
    alu_data_t res_d;
    logic      flag_d;

    // bitwise compare
    assign cmp_res = stage_a ^ stage_b;

    // and-or select over the one-hot unit controls
    assign res_d = ({DATA_W{stage_ctrl.sel_add}} & sum)
                 | ({DATA_W{stage_ctrl.sel_mul}} & product[DATA_W-1:0])
                 | ({DATA_W{stage_ctrl.sel_cmp}} & cmp_res);

    // carry for add, borrow for subtract, range flag for multiply
    assign flag_d = (stage_ctrl.sel_add & (carry ^ stage_ctrl.sub))
                  | (stage_ctrl.sel_mul & mul_overflow);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result       <= '0;
            overflow     <= 1'b0;
        end else begin
            result_valid <= stage_valid;
            if (stage_valid) begin
                result   <= res_d;
                overflow <= flag_d;
            end else begin
                // idle cycles show zero
                result   <= '0;
                overflow <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/csa_multiplier.sv ====
`timescale 1ns/10ps

module csa_multiplier
    import alu_pkg::*;
#(
    parameter int DATA_W = data_width
) (
    input  alu_data_t a,
    input  alu_data_t b,
    input  logic      mul_signed,
    output alu_prod_t product,
    output logic      mul_overflow
);

    localparam int prod_w = 2 * DATA_W;
    // one row per multiplier bit plus the Baugh-Wooley constant row
    localparam int rows = DATA_W + 1;

    logic [prod_w-1:0] pp [rows];
    logic [prod_w-1:0] csa_s [DATA_W];
    logic [prod_w-1:0] csa_c [DATA_W];
    logic [prod_w-1:0] full_prod;
    logic [DATA_W:0]   sign_bits;

    // shifted partial products
    // in signed mode the bits where exactly one operand sign bit takes part are inverted
    always_comb begin
        for (int i = 0; i < DATA_W; i++) begin
            pp[i] = '0;
            for (int j = 0; j < DATA_W; j++) begin
                pp[i][i+j] = (a[j] & b[i])
                           ^ (mul_signed & ((i == DATA_W-1) != (j == DATA_W-1)));
            end
        end
        // correction constants 2^n and 2^(2n-1)
        pp[DATA_W]           = '0;
        pp[DATA_W][DATA_W]   = mul_signed;
        pp[DATA_W][prod_w-1] = mul_signed;
    end

    // first two rows seed the sum and carry vectors
    assign csa_s[0] = pp[0];
    assign csa_c[0] = pp[1];

    // each row of full adders folds one more partial product in
    for (genvar k = 0; k < DATA_W-1; k++) begin : g_csa_row
        logic [prod_w-1:0] maj;

        assign csa_s[k+1] = csa_s[k] ^ csa_c[k] ^ pp[k+2];
        assign maj        = (csa_s[k] & csa_c[k])
                          | (csa_s[k] & pp[k+2])
                          | (csa_c[k] & pp[k+2]);
        // carries move up one column, the top one falls off modulo 2^(2n)
        assign csa_c[k+1] = {maj[prod_w-2:0], 1'b0};
    end

    // carry-propagate add of the last sum and carry vectors
    assign full_prod = csa_s[DATA_W-1] + csa_c[DATA_W-1];
    assign product   = full_prod;

    // bits that must all match the sign for a signed result to fit
    assign sign_bits = full_prod[prod_w-1:DATA_W-1];

    always_comb begin
        if (mul_signed) begin
            mul_overflow = !((&sign_bits) || !(|sign_bits));
        end else begin
            mul_overflow = |full_prod[prod_w-1:DATA_W];
        end
    end

endmodule

// ==== logic/cla_adder.sv ====
`timescale 1ns/10ps

module cla_adder
    import alu_pkg::*;
#(
    parameter int DATA_W = data_width
) (
    input  alu_data_t a,
    input  alu_data_t b,
    input  logic      sub,
    output alu_data_t sum,
    output logic      carry
);

    localparam int groups = DATA_W / 4;

    logic [DATA_W-1:0] b_eff;
    logic [DATA_W-1:0] g;
    logic [DATA_W-1:0] p;
    logic [DATA_W:0]   c;

    // two's complement subtract: invert b and inject a carry
    assign b_eff = b ^ {DATA_W{sub}};
    assign g     = a & b_eff;
    assign p     = a ^ b_eff;
    assign c[0]  = sub;

    for (genvar grp = 0; grp < groups; grp++) begin : g_group
        localparam int base = grp * 4;
        logic [3:0] gg;
        logic [3:0] pp;
        logic       cin;
        logic       blk_g;
        logic       blk_p;

        assign gg  = g[base +: 4];
        assign pp  = p[base +: 4];
        assign cin = c[base];

        assign c[base+1] = gg[0] | (pp[0] & cin);
        assign c[base+2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & cin);
        assign c[base+3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                         | (pp[2] & pp[1] & pp[0] & cin);

        // block generate and propagate give the carry into the next group
        assign blk_g = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                     | (pp[3] & pp[2] & pp[1] & gg[0]);
        assign blk_p = &pp;

        assign c[base+4] = blk_g | (blk_p & cin);
    end

    assign sum   = p ^ c[DATA_W-1:0];
    // raw carry out, low on subtract means a borrow
    assign carry = c[DATA_W];

endmodule

// ==== logic/instr_decode.sv ====
`timescale 1ns/10ps

module instr_decode
    import alu_pkg::*;
#(
    parameter int DATA_W = data_width
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  alu_instr_t instr,
    output logic       stage_valid,
    output alu_data_t  stage_a,
    output alu_data_t  stage_b,
    output alu_ctrl_t  stage_ctrl
);

    alu_ctrl_t ctrl_d;

    // opcode to unit select, subtract and signed mode
    always_comb begin
        ctrl_d = '0;
        case (instr.op)
            op_add: begin
                ctrl_d.sel_add = 1'b1;
            end
            op_sub: begin
                ctrl_d.sel_add = 1'b1;
                ctrl_d.sub     = 1'b1;
            end
            op_mulu: begin
                ctrl_d.sel_mul = 1'b1;
            end
            op_muls: begin
                ctrl_d.sel_mul    = 1'b1;
                ctrl_d.mul_signed = 1'b1;
            end
            op_cmp: begin
                ctrl_d.sel_cmp = 1'b1;
            end
            // op_none and the reserved float opcodes leave every select low
            default: begin
                ctrl_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            stage_ctrl  <= '0;
        end else begin
            stage_valid <= instr_valid;
            stage_ctrl  <= ctrl_d;
        end
    end

    // operand registers
    always_ff @(posedge clk) begin
        stage_a <= instr.a[DATA_W-1:0];
        stage_b <= instr.b[DATA_W-1:0];
    end

endmodule

// ==== logic/alu_pkg.sv ====
package alu_pkg;

    // operand width of the integer datapath
    localparam int data_width = 8;

    // opcode field width, numbering kept from the original gate-level ALU
    localparam int op_width = 3;

    typedef logic [data_width-1:0] alu_data_t;

    // full double-width product before truncation
    typedef logic [2*data_width-1:0] alu_prod_t;

    typedef enum logic [op_width-1:0] {
        op_none = 3'd0,
        op_add  = 3'd1,
        op_sub  = 3'd2,
        op_mulu = 3'd3,
        op_muls = 3'd4,
        // float opcodes are reserved and return zero
        op_fadd = 3'd5,
        op_fmul = 3'd6,
        op_cmp  = 3'd7
    } alu_op_e;

    // 19-bit instruction word, opcode in the top bits
    typedef struct packed {
        alu_op_e   op;
        alu_data_t a;
        alu_data_t b;
    } alu_instr_t;

    // decoded controls, unit selects are one-hot or all low for a zero result
    typedef struct packed {
        logic sel_add;
        logic sel_mul;
        logic sel_cmp;
        logic sub;
        logic mul_signed;
    } alu_ctrl_t;

endpackage
